// File: filelist.f
shaper_cfg_pkg.sv
shaper_types_pkg.sv
shaper_fsm.sv
shift_bit_counter.sv
sample_shift_reg.sv
error_accum.sv
delta_shaper_top.sv
tb_delta_shaper.sv

// File: Bender.yml
package:
  name: delta_shaper

sources:
  - shaper_cfg_pkg.sv
  - shaper_types_pkg.sv
  - shaper_fsm.sv
  - shift_bit_counter.sv
  - sample_shift_reg.sv
  - error_accum.sv
  - delta_shaper_top.sv
  - target: test
    files:
      - tb_delta_shaper.sv

// File: tb_delta_shaper.sv
`timescale 1ns/1ps
`default_nettype none

module tb_delta_shaper;
	import shaper_cfg_pkg::*;
	import shaper_types_pkg::*;

	localparam int SW = SAMPLE_W_DEFAULT;
	localparam logic [SW:0] FS = FULL_SCALE_DEFAULT; // zero extended to the residual width
	localparam logic [SW-1:0] HALF = FULL_SCALE_DEFAULT >> 1;

	logic clk;
	logic rst_n;
	logic start;
	logic ready;
	logic value;
	logic delta;
	logic transfer;

	logic [SW:0]   model_res;    // residual the DUT should hold
	logic [SW-1:0] model_sample; // last sample fully shifted in
	int            errors;
	int            checks;
	int            tests;
	int            passed;
	int            err_mark;
	int            ones;
	longint        sum_used;     // sum of the samples consumed by starts
	longint        expected_ones;
	bit            seen;
	logic          held_delta;
	int            seed_dummy;

	delta_shaper_top uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.ready    (ready),
		.value    (value),
		.delta    (delta),
		.transfer (transfer)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic expect_true(input bit ok, input string msg);
		checks++;
		assert (ok) else
		begin
			$display("ERROR @%0t: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == err_mark)
			passed++;
		$display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "failed");
		err_mark = errors;
	endtask

	// one start, the model update, and a serial load if the DUT asks for it
	task automatic run_round(input logic rdy, input logic [SW-1:0] next_sample,
		input bit poke_start);
		logic [SW:0]   sum;
		logic          exp_over;
		int            i;
		shaper_state_e st;
		ready = rdy;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		sum       = model_res + model_sample;
		exp_over  = (sum >= FS);
		model_res = exp_over ? sum - FS : sum;
		sum_used += model_sample;
		seen = 1'b0;
		for (i = 0; i < 6 && !seen; i++)
		begin
			@(negedge clk);
			if (transfer)
				seen = 1'b1;
		end
		expect_true(delta === exp_over,
			$sformatf("delta %0b, model expects %0b", delta, exp_over));
		if (delta === 1'b1)
			ones++;
		if (rdy)
		begin
			checks++;
			assert (seen) else
			begin
				st = uut.u_fsm.state;
				$display("no transfer within 6 cycles of the start at %0t, FSM in %s",
					$time, st.name());
				errors++;
			end
		end
		else
			expect_true(!seen, "transfer pulsed although ready was low");
		if (seen)
		begin
			for (i = SW - 1; i >= 0; i--)
			begin
				value = next_sample[i]; // msb goes first
				start = poke_start && (i % 4 == 1);
				@(negedge clk);
				expect_true(transfer === 1'b0, "transfer lasted longer than one cycle");
			end
			start = 1'b0;
			model_sample = next_sample;
		end
	endtask

	task automatic idle_check(input int cycles);
		int i;
		for (i = 0; i < cycles; i++)
		begin
			@(negedge clk);
			expect_true(transfer === 1'b0, "transfer appeared while idle");
			expect_true(delta === held_delta, "delta moved while idle");
		end
	endtask

	// load a constant, then count ones over the following rounds
	task automatic density_run(input logic [SW-1:0] c, input int mode, input string name);
		int i;
		int n_ones;
		int zero_pairs;
		int one_pairs;
		logic prev;
		n_ones     = 0;
		zero_pairs = 0;
		one_pairs  = 0;
		prev       = 1'b0;
		run_round(1'b1, c, 1'b0);
		for (i = 0; i < 32; i++)
		begin
			run_round(1'b1, c, 1'b0);
			if (delta)
				n_ones++;
			if (i > 0 && prev && delta)
				one_pairs++;
			if (i > 0 && !prev && !delta)
				zero_pairs++;
			prev = delta;
		end
		case (mode)
			0: expect_true(n_ones == 0, $sformatf("%s: %0d ones, none expected", name, n_ones));
			2: expect_true(n_ones == 32, $sformatf("%s: %0d ones of 32", name, n_ones));
			default:
				// HALF rounds down, so a zero repeats about once per 2^16 rounds
				expect_true(one_pairs == 0 && zero_pairs <= 1,
					$sformatf("%s: %0d double ones, %0d double zeros", name, one_pairs,
					zero_pairs));
		endcase
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial
	begin
		rst_n = 1'b0;
		start = 1'b0;
		ready = 1'b0;
		value = 1'b0;
		model_res    = '0;
		model_sample = '0;
		errors   = 0;
		checks   = 0;
		tests    = 0;
		passed   = 0;
		err_mark = 0;
		ones     = 0;
		sum_used = 0;
		seed_dummy = $urandom(41);
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		expect_true(delta === 1'b0 && transfer === 1'b0, "outputs not zero after reset");
		held_delta = 1'b0;
		idle_check(20);
		report_test("reset and idle");

		for (int k = 0; k < 200; k++)
			run_round(1'b1, SW'($urandom), 1'b0);
		report_test("random rounds, ready high");

		for (int k = 0; k < 10; k++)
			run_round(1'b0, SW'($urandom), 1'b0); // sample must stay as it is
		report_test("ready low keeps sample");

		ones     = 0;
		sum_used = 0;
		for (int k = 0; k < 400; k++)
			run_round(($urandom % 4) != 0, SW'($urandom), 1'b0);
		expected_ones = sum_used / FS; // signed copy so the differences below may go negative
		expect_true((ones - expected_ones) <= 1 && (expected_ones - ones) <= 1,
			$sformatf("%0d ones, sum %0d gives %0d", ones, sum_used, expected_ones));
		report_test("long run density");

		for (int k = 0; k < 5; k++)
		begin
			run_round(1'b1, SW'($urandom), 1'b1);
			held_delta = delta;
			idle_check(20);
		end
		report_test("start during shift ignored");

		density_run('0, 0, "zero");
		density_run(HALF, 1, "half scale");
		density_run(FULL_SCALE_DEFAULT, 2, "full scale");
		report_test("constant densities");

		$display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
			tests, passed, tests - passed, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: delta_shaper_top.sv
`timescale 1ns/1ps
`default_nettype none

module delta_shaper_top #(
	parameter int                  SAMPLE_W   = shaper_cfg_pkg::SAMPLE_W_DEFAULT,
	parameter logic [SAMPLE_W-1:0] FULL_SCALE = shaper_cfg_pkg::FULL_SCALE_DEFAULT
) (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic ready,
	input  logic value,
	output logic delta,
	output logic transfer
);
	import shaper_types_pkg::*;

	shaper_ctrl_t        ctrl;   // FSM strobes to all data blocks
	accum_stat_t         stat;   // overflow flag back to the FSM
	logic [SAMPLE_W-1:0] sample; // last complete sample
	logic                done;   // last shift cycle of a load

	//////////////////////////////
	// control
	//////////////////////////////

	shaper_fsm u_fsm (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.ready    (ready),
		.done     (done),
		.stat     (stat),
		.ctrl     (ctrl),
		.delta    (delta),
		.transfer (transfer)
	);

	shift_bit_counter #(
		.SAMPLE_W (SAMPLE_W)
	) u_bit_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.ctrl  (ctrl),
		.done  (done)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////

	sample_shift_reg #(
		.SAMPLE_W (SAMPLE_W)
	) u_sample (
		.clk    (clk),
		.rst_n  (rst_n),
		.value  (value),
		.ctrl   (ctrl),
		.sample (sample)
	);

	error_accum #(
		.SAMPLE_W   (SAMPLE_W),
		.FULL_SCALE (FULL_SCALE)
	) u_accum (
		.clk    (clk),
		.rst_n  (rst_n),
		.ctrl   (ctrl),
		.sample (sample),
		.stat   (stat)
	);

endmodule

`default_nettype wire

// File: error_accum.sv
`timescale 1ns/1ps
`default_nettype none

module error_accum #(
	parameter int                  SAMPLE_W   = shaper_cfg_pkg::SAMPLE_W_DEFAULT,
	parameter logic [SAMPLE_W-1:0] FULL_SCALE = shaper_cfg_pkg::FULL_SCALE_DEFAULT
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  shaper_types_pkg::shaper_ctrl_t ctrl,
	input  logic [SAMPLE_W-1:0]            sample,
	output shaper_types_pkg::accum_stat_t  stat
);
	import shaper_cfg_pkg::*;

	localparam int ACC_W = acc_width(SAMPLE_W);
	localparam logic [ACC_W-1:0] FS_EXT = ACC_W'(FULL_SCALE);

	logic [ACC_W-1:0] residual; // quantisation error carried to the next round
	logic [ACC_W-1:0] sum;

	//////////////////////////////
	// add and compare
	//////////////////////////////

	// residual stays below full scale, so the sum never needs more than ACC_W bits
	assign sum = residual + ACC_W'(sample);

	assign stat.over = (sum >= FS_EXT); // reaching full scale counts as overflow

	//////////////////////////////
	// residual register
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			residual <= '0;
		else if (ctrl.accum_en)
			residual <= sum;
		else if (ctrl.sub_en)
			residual <= residual - FS_EXT; // one full scale leaves as a delta pulse
	end

	// accum_en and sub_en come from different states and never overlap

endmodule

`default_nettype wire

// File: sample_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

module sample_shift_reg #(
	parameter int SAMPLE_W = shaper_cfg_pkg::SAMPLE_W_DEFAULT
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           value,
	input  shaper_types_pkg::shaper_ctrl_t ctrl,
	output logic [SAMPLE_W-1:0]            sample
);

	// msb arrives first, so every new bit pushes the older ones up
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sample <= '0;
		else if (ctrl.shift_en)
			sample <= {sample[SAMPLE_W-2:0], value};
	end

	// between loads the register simply holds, so an unready source
	// leaves the previous sample in place for the next start

endmodule

`default_nettype wire

// File: shift_bit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module shift_bit_counter #(
	parameter int SAMPLE_W = shaper_cfg_pkg::SAMPLE_W_DEFAULT
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  shaper_types_pkg::shaper_ctrl_t ctrl,
	output logic                           done
);
	import shaper_cfg_pkg::*;

	localparam int CNT_W = cnt_width(SAMPLE_W);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SAMPLE_W - 1);

	logic [CNT_W-1:0] count; // shift cycles already completed in this load

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			count <= '0;
		else if (ctrl.count_clr)
			count <= '0;
		else if (ctrl.shift_en)
			count <= count + 1'b1;
	end

	// done marks the cycle in which the SAMPLE_W-th bit goes in
	assign done = ctrl.shift_en && (count == LAST_BIT);

endmodule

`default_nettype wire

// File: shaper_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module shaper_fsm (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           start,
	input  logic                           ready,
	input  logic                           done,
	input  shaper_types_pkg::accum_stat_t  stat,
	output shaper_types_pkg::shaper_ctrl_t ctrl,
	output logic                           delta,
	output logic                           transfer
);
	import shaper_types_pkg::*;

	shaper_state_e state;
	shaper_state_e state_nxt;

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_WAIT:
				if (start)
					state_nxt = ST_ACCUM; // start is only looked at here
			ST_ACCUM:
				state_nxt = stat.over ? ST_SUB : ST_CHECK;
			ST_SUB:
				state_nxt = ST_CHECK;
			ST_CHECK:
				state_nxt = ready ? ST_SHIFT : ST_WAIT; // not ready keeps the old sample
			ST_SHIFT:
				if (done)
					state_nxt = ST_WAIT;
			default:
				state_nxt = ST_WAIT;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= ST_WAIT;
		else
			state <= state_nxt;
	end

	//////////////////////////////
	// outputs
	//////////////////////////////

	// delta only moves when leaving ST_ACCUM and holds otherwise
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			delta    <= 1'b0;
			transfer <= 1'b0;
		end
		else
		begin
			if (state == ST_ACCUM)
				delta <= stat.over;
			transfer <= (state == ST_CHECK) && ready; // high for the first shift cycle only
		end
	end

	// strobes are decoded straight from the state register
	always_comb
	begin
		ctrl           = '0;
		ctrl.accum_en  = (state == ST_ACCUM);
		ctrl.sub_en    = (state == ST_SUB);
		ctrl.shift_en  = (state == ST_SHIFT);
		ctrl.count_clr = (state == ST_CHECK) && ready; // counter starts at zero on entry to shift
	end

endmodule

`default_nettype wire

// File: shaper_types_pkg.sv
`default_nettype none

package shaper_types_pkg;

	//////////////////////////////
	// sequencer states
	//////////////////////////////

	typedef enum logic [2:0] {
		ST_WAIT  = 3'd0, // idle until start
		ST_ACCUM = 3'd1, // add sample, register delta
		ST_SUB   = 3'd2, // remove full scale after an overflow
		ST_CHECK = 3'd3, // look at ready once
		ST_SHIFT = 3'd4  // serial load of the next sample
	} shaper_state_e;

	//////////////////////////////
	// control and status
	//////////////////////////////

	// strobes from the FSM to the data blocks
	typedef struct packed {
		logic accum_en;  // residual takes residual plus sample
		logic sub_en;    // residual drops by full scale
		logic shift_en;  // one serial bit moves in and is counted
		logic count_clr; // bit counter back to zero before a load
	} shaper_ctrl_t;

	// the accumulator reports only whether the next add reaches full scale
	typedef struct packed {
		logic over;
	} accum_stat_t;

endpackage

`default_nettype wire

// File: shaper_cfg_pkg.sv
`default_nettype none

package shaper_cfg_pkg;

	//////////////////////////////
	// sizing defaults
	//////////////////////////////

	localparam int SAMPLE_W_DEFAULT = 16; // bits per serially loaded sample
	localparam logic [15:0] FULL_SCALE_DEFAULT = 16'hFFFF; // overflow threshold of the loop

	//////////////////////////////
	// derived widths
	//////////////////////////////

	// the bit counter must reach SAMPLE_W-1 and still have headroom for one more step
	function automatic int cnt_width(input int sample_w);
		return $clog2(sample_w) + 1;
	endfunction

	// one extra bit keeps residual plus sample from wrapping
	function automatic int acc_width(input int sample_w);
		return sample_w + 1;
	endfunction

endpackage

`default_nettype wire
